// File: source/mul_defs.svh
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand and product widths
`define MUL_WIDTH 32
`define MUL_PRODUCT_WIDTH (2 * `MUL_WIDTH)

// Rows folded into one clock step, must divide MUL_WIDTH
`define MUL_ROWS_PER_STEP 4
`define MUL_STEPS (`MUL_WIDTH / `MUL_ROWS_PER_STEP)

// Consumer buffer depth, also the starting credit count
`define MUL_RESULT_CREDITS 2

`endif

// File: source/mul_pkg.sv
`default_nettype none

`include "mul_defs.svh"

package mul_pkg;

	// Redundant form of a partial sum, value is sum + (carry << 1)
	typedef struct packed {
		logic [`MUL_PRODUCT_WIDTH-1:0] sum;
		logic [`MUL_PRODUCT_WIDTH-1:0] carry;
	} csa_pair_t;

	// Partial-product rows handled in one step
	typedef logic [`MUL_ROWS_PER_STEP-1:0][`MUL_PRODUCT_WIDTH-1:0] pp_rows_t;

	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		ACCUMULATE = 2'd1,
		RESOLVE    = 2'd2,
		SEND       = 2'd3
	} mul_state_t;

endpackage

`default_nettype wire

// File: source/mul_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mul_ctrl_if (
	input logic clk,
	input logic reset
);

	// Step controls from the sequencer
	logic load;
	logic accumulate;
	logic resolve;

	// From the step counter
	logic last_step;

	modport control (
		input  clk,
		input  reset,
		input  last_step,
		output load,
		output accumulate,
		output resolve
	);

	modport counter (
		input  clk,
		input  reset,
		input  load,
		input  accumulate,
		output last_step
	);

	modport datapath (
		input  clk,
		input  load,
		input  accumulate,
		input  resolve
	);

endinterface

`default_nettype wire

// File: source/mul_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_control
	import mul_pkg::*;
(
	mul_ctrl_if.control ctrl,
	input  logic        op_valid,
	output logic        op_ready,
	input  logic        res_credit,
	output logic        res_valid
);

	localparam int CREDIT_W = $clog2(`MUL_RESULT_CREDITS + 1);

	mul_state_t state;
	mul_state_t state_next;
	logic [CREDIT_W-1:0] credits;
	logic accept;

	// New operands only while no operation is in flight
	assign op_ready = (state == IDLE);
	assign accept = op_valid && op_ready;

	assign ctrl.load = accept;
	assign ctrl.accumulate = (state == ACCUMULATE);
	assign ctrl.resolve = (state == RESOLVE);

	// Result goes out only when the consumer has room
	assign res_valid = (state == SEND) && (credits != '0);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = ACCUMULATE;
				end
			end
			ACCUMULATE: begin
				// Counter marks the final step
				if (ctrl.last_step) begin
					state_next = RESOLVE;
				end
			end
			RESOLVE: begin
				state_next = SEND;
			end
			SEND: begin
				if (res_valid) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge ctrl.clk) begin
		if (ctrl.reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Spend on res_valid, refill on res_credit, both at once cancel out
	always_ff @(posedge ctrl.clk) begin
		if (ctrl.reset) begin
			credits <= CREDIT_W'(`MUL_RESULT_CREDITS);
		end else if (res_valid && !res_credit) begin
			credits <= credits - 1'b1;
		end else if (!res_valid && res_credit) begin
			credits <= credits + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/mul_step_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_step_counter (
	mul_ctrl_if.counter ctrl
);

	localparam int STEP_W = (`MUL_STEPS > 1) ? $clog2(`MUL_STEPS) : 1;

	logic [STEP_W-1:0] step_count;

	always_ff @(posedge ctrl.clk) begin
		if (ctrl.reset) begin
			step_count <= '0;
		end else if (ctrl.load) begin
			step_count <= '0;
		end else if (ctrl.accumulate) begin
			step_count <= step_count + 1'b1;
		end
	end

	// High during the final accumulate cycle
	assign ctrl.last_step = ctrl.accumulate
		&& (step_count == STEP_W'(`MUL_STEPS - 1));

endmodule

`default_nettype wire

// File: source/mul_operand_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_operand_store
	import mul_pkg::*;
(
	mul_ctrl_if.datapath           ctrl,
	input  logic [`MUL_WIDTH-1:0]  op_a,
	input  logic [`MUL_WIDTH-1:0]  op_b,
	output pp_rows_t               pp_rows
);

	// Multiplicand already aligned to the current step's weight
	logic [`MUL_PRODUCT_WIDTH-1:0] multiplicand;
	// Multiplier bits not yet consumed, lowest first
	logic [`MUL_WIDTH-1:0] multiplier;

	always_ff @(posedge ctrl.clk) begin
		if (ctrl.load) begin
			multiplicand <= {{(`MUL_PRODUCT_WIDTH - `MUL_WIDTH){1'b0}}, op_a};
			multiplier <= op_b;
		end else if (ctrl.accumulate) begin
			multiplicand <= multiplicand << `MUL_ROWS_PER_STEP;
			multiplier <= multiplier >> `MUL_ROWS_PER_STEP;
		end
	end

	// Row j is a & b[k], placed at weight k
	always_comb begin
		for (int j = 0; j < `MUL_ROWS_PER_STEP; j++) begin
			if (multiplier[j]) begin
				pp_rows[j] = multiplicand << j;
			end else begin
				pp_rows[j] = '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/mul_csa_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_csa_accumulator
	import mul_pkg::*;
(
	mul_ctrl_if.datapath ctrl,
	input  pp_rows_t     pp_rows,
	output csa_pair_t    csa_pair
);

	localparam int W = `MUL_PRODUCT_WIDTH;
	localparam int ROWS = `MUL_ROWS_PER_STEP;

	csa_pair_t pair;

	// Index 0 is the stored pair, index ROWS the result of the last row
	logic [ROWS:0][W-1:0] row_sum;
	logic [ROWS:0][W-1:0] row_carry;

	// Chained carry-save rows, one full-adder cell per bit
	always_comb begin
		logic [W-1:0] carry_in;
		logic fa_a;
		logic fa_b;
		logic fa_c;

		row_sum[0] = pair.sum;
		row_carry[0] = pair.carry;
		for (int r = 0; r < ROWS; r++) begin
			// Carry moves one place up, bit 63 falls off
			carry_in = {row_carry[r][W-2:0], 1'b0};
			for (int i = 0; i < W; i++) begin
				fa_a = row_sum[r][i];
				fa_b = carry_in[i];
				fa_c = pp_rows[r][i];
				row_sum[r+1][i] = fa_a ^ fa_b ^ fa_c;
				row_carry[r+1][i] = (fa_a & fa_b) | (fa_c & (fa_a ^ fa_b));
			end
		end
	end

	always_ff @(posedge ctrl.clk) begin
		if (ctrl.load) begin
			pair.sum <= '0;
			pair.carry <= '0;
		end else if (ctrl.accumulate) begin
			pair.sum <= row_sum[ROWS];
			pair.carry <= row_carry[ROWS];
		end
	end

	assign csa_pair = pair;

endmodule

`default_nettype wire

// File: source/mul_carry_resolve.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_carry_resolve
	import mul_pkg::*;
(
	mul_ctrl_if.datapath                   ctrl,
	input  csa_pair_t                      csa_pair,
	output logic [`MUL_PRODUCT_WIDTH-1:0]  product
);

	localparam int W = `MUL_PRODUCT_WIDTH;

	logic [W-1:0] carry_shifted;
	logic [W-1:0] ripple_sum;

	assign carry_shifted = {csa_pair.carry[W-2:0], 1'b0};

	// Final row of the array, carry ripples from bit 0 upward
	always_comb begin
		logic ripple;
		logic fa_a;
		logic fa_b;

		ripple = 1'b0;
		for (int i = 0; i < W; i++) begin
			fa_a = csa_pair.sum[i];
			fa_b = carry_shifted[i];
			ripple_sum[i] = fa_a ^ fa_b ^ ripple;
			// Carry out of bit 63 is never needed
			ripple = (fa_a & fa_b) | (ripple & (fa_a ^ fa_b));
		end
	end

	// Held until the next operation resolves
	always_ff @(posedge ctrl.clk) begin
		if (ctrl.resolve) begin
			product <= ripple_sum;
		end
	end

endmodule

`default_nettype wire

// File: source/mul_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_top
	import mul_pkg::*;
(
	input  logic                           clk,
	input  logic                           reset,

	// Operand side, valid/ready
	input  logic                           op_valid,
	output logic                           op_ready,
	input  logic [`MUL_WIDTH-1:0]          op_a,
	input  logic [`MUL_WIDTH-1:0]          op_b,

	// Result side, credit based
	output logic                           res_valid,
	output logic [`MUL_PRODUCT_WIDTH-1:0]  res_product,
	input  logic                           res_credit
);

	pp_rows_t pp_rows;
	csa_pair_t csa_pair;

	mul_ctrl_if ctrl_if (
		.clk   (clk),
		.reset (reset)
	);

	mul_control control_i (
		.ctrl       (ctrl_if.control),
		.op_valid   (op_valid),
		.op_ready   (op_ready),
		.res_credit (res_credit),
		.res_valid  (res_valid)
	);

	mul_step_counter step_counter_i (
		.ctrl (ctrl_if.counter)
	);

	// Datapath, operands to rows to carry-save pair to product
	mul_operand_store operand_store_i (
		.ctrl    (ctrl_if.datapath),
		.op_a    (op_a),
		.op_b    (op_b),
		.pp_rows (pp_rows)
	);

	mul_csa_accumulator csa_accumulator_i (
		.ctrl     (ctrl_if.datapath),
		.pp_rows  (pp_rows),
		.csa_pair (csa_pair)
	);

	mul_carry_resolve carry_resolve_i (
		.ctrl     (ctrl_if.datapath),
		.csa_pair (csa_pair),
		.product  (res_product)
	);

endmodule

`default_nettype wire

// File: tb/mul_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_top_tb;

	localparam int RESET_CYCLES = 10;
	localparam int RESULT_LATENCY = 10;
	localparam int NUM_VECTORS = 13;
	localparam int NUM_RANDOM = 32;
	localparam int SAME_CYCLE_OPS = 4;
	// Credit return lands on the pulse of the next back-to-back result
	localparam int SAME_CYCLE_HOLD = 11;
	localparam int STALL_CYCLES = 20;
	localparam int MAX_HOLD = STALL_CYCLES;
	localparam int NUM_OPS = NUM_VECTORS + NUM_RANDOM + `MUL_RESULT_CREDITS + 1 + SAME_CYCLE_OPS;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * (RESULT_LATENCY + MAX_HOLD + 4);
	localparam int NEVER = 2147483647;
	localparam logic [31:0] LFSR_SEED = 32'd13;

	typedef struct packed {
		logic [`MUL_WIDTH-1:0] a;
		logic [`MUL_WIDTH-1:0] b;
		logic [`MUL_PRODUCT_WIDTH-1:0] product;
		int hold;
	} vector_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic op_valid = 1'b0;
	logic op_ready;
	logic [`MUL_WIDTH-1:0] op_a = '0;
	logic [`MUL_WIDTH-1:0] op_b = '0;
	logic res_valid;
	logic [`MUL_PRODUCT_WIDTH-1:0] res_product;
	logic res_credit = 1'b0;

	vector_t vectors [NUM_VECTORS];
	logic [31:0] lfsr_state = LFSR_SEED;
	int cycle_count = 0;
	// Cycle in which each held consumer slot hands its credit back
	int release_q[$];

	mul_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.op_valid    (op_valid),
		.op_ready    (op_ready),
		.op_a        (op_a),
		.op_b        (op_b),
		.res_valid   (res_valid),
		.res_product (res_product),
		.res_credit  (res_credit)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "run stopped at the first failing check");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
			abort_run();
		end
	endtask

	// Galois form, taps for x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'hD000_0001;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < count; i++) begin
			word = {word[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return word;
	endfunction

	// Model consumer, one credit back per edge once its slot is due
	always @(posedge clk) begin : credit_return
		int due;
		due = -1;
		foreach (release_q[i]) begin
			if (due < 0 && release_q[i] <= cycle_count + 1) begin
				due = i;
			end
		end
		if (due >= 0) begin
			release_q.delete(due);
			res_credit <= 1'b1;
		end else begin
			res_credit <= 1'b0;
		end
		cycle_count <= cycle_count + 1;
	end

	always @(posedge clk) begin
		assert (cycle_count < TIMEOUT_CYCLES) else begin
			$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// Presents operands, returns right after the accept edge
	task automatic send_operands(input logic [`MUL_WIDTH-1:0] a, input logic [`MUL_WIDTH-1:0] b);
		@(posedge clk);
		op_valid <= 1'b1;
		op_a <= a;
		op_b <= b;
		@(negedge clk);
		check_value("op_ready", 64'd1, 64'(op_ready));
		@(posedge clk);
		// Garbage while busy must not reach the result
		op_a <= random_bits(32);
		op_b <= random_bits(32);
	endtask

	task automatic collect_result(input logic [63:0] expected, input int hold, input bit held,
		input int limit, input bit exact);
		int latency;
		latency = 0;
		do begin
			@(negedge clk);
			latency++;
			check_value("op_ready", 64'd0, 64'(op_ready));
			if (!res_valid) begin
				assert (latency < limit) else begin
					$display("no result arrived within %0d cycles", limit);
					abort_run();
				end
				@(posedge clk);
				op_a <= random_bits(32);
				op_b <= random_bits(32);
			end
		end while (!res_valid);
		if (exact) begin
			check_value("res_valid latency", 64'(limit), 64'(latency));
		end
		check_value("res_product", expected, res_product);
		release_q.push_back(held ? NEVER : cycle_count + hold);
		assert (release_q.size() <= `MUL_RESULT_CREDITS) else begin
			$display("consumer received more results than it has slots");
			abort_run();
		end
	endtask

	task automatic expect_stall(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_value("res_valid", 64'd0, 64'(res_valid));
			check_value("op_ready", 64'd0, 64'(op_ready));
			@(posedge clk);
			op_a <= random_bits(32);
			op_b <= random_bits(32);
		end
	endtask

	// Called in the second half of a cycle
	task automatic release_held_credit();
		int idx;
		idx = -1;
		foreach (release_q[i]) begin
			if (idx < 0 && release_q[i] == NEVER) begin
				idx = i;
			end
		end
		assert (idx >= 0) else begin
			$display("no withheld credit was left to return");
			abort_run();
		end
		release_q[idx] = cycle_count + 1;
	endtask

	// Idle until every outstanding credit is back
	task automatic drain_credits();
		int waited;
		waited = 0;
		@(posedge clk);
		op_valid <= 1'b0;
		while (release_q.size() != 0) begin
			@(negedge clk);
			waited++;
			assert (waited <= MAX_HOLD + 2) else begin
				$display("outstanding credits were never returned");
				abort_run();
			end
		end
	endtask

	initial begin : stimulus
		logic [`MUL_WIDTH-1:0] a;
		logic [`MUL_WIDTH-1:0] b;
		int hold;

		// Operand a, operand b, product, cycles until the credit goes back
		vectors = '{
			'{32'h0000_0000, 32'hDEAD_BEEF, 64'h0000_0000_0000_0000, 3},
			'{32'h1234_5678, 32'h0000_0000, 64'h0000_0000_0000_0000, 1},
			'{32'h0000_0001, 32'hCAFE_F00D, 64'h0000_0000_CAFE_F00D, 5},
			'{32'h89AB_CDEF, 32'h0000_0001, 64'h0000_0000_89AB_CDEF, 11},
			'{32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001, 11},
			'{32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 2},
			'{32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000, 7},
			'{32'h0000_0002, 32'h4000_0000, 64'h0000_0000_8000_0000, 4},
			'{32'hFFFF_FFFF, 32'h8000_0000, 64'h7FFF_FFFF_8000_0000, 9},
			'{32'hAAAA_AAAA, 32'h5555_5555, 64'h38E3_8E38_71C7_1C72, 11},
			'{32'h5555_5555, 32'h5555_5555, 64'h1C71_C71C_38E3_8E39, 6},
			'{32'hAAAA_AAAA, 32'hAAAA_AAAA, 64'h71C7_1C70_E38E_38E4, 1},
			'{32'hFFFF_FFFF, 32'h0000_0002, 64'h0000_0001_FFFF_FFFE, 8}
		};

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			if (i == RESET_CYCLES - 1) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			check_value("res_valid", 64'd0, 64'(res_valid));
			check_value("op_ready", 64'd1, 64'(op_ready));
		end

		for (int i = 0; i < NUM_VECTORS; i++) begin
			send_operands(vectors[i].a, vectors[i].b);
			collect_result(vectors[i].product, vectors[i].hold, 1'b0, RESULT_LATENCY, 1'b1);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			a = random_bits(32);
			b = random_bits(32);
			hold = int'(random_bits(3)) + 1;
			send_operands(a, b);
			collect_result(64'(a) * 64'(b), hold, 1'b0, RESULT_LATENCY, 1'b1);
		end

		// Back-pressure, the consumer keeps every slot it fills
		drain_credits();
		for (int i = 0; i < `MUL_RESULT_CREDITS; i++) begin
			a = random_bits(32);
			b = random_bits(32);
			send_operands(a, b);
			collect_result(64'(a) * 64'(b), 0, 1'b1, RESULT_LATENCY, 1'b1);
		end
		a = random_bits(32);
		b = random_bits(32);
		send_operands(a, b);
		expect_stall(STALL_CYCLES);
		@(negedge clk);
		release_held_credit();
		collect_result(64'(a) * 64'(b), 2, 1'b0, 4, 1'b0);
		// Second slot freed before the pulse ends, so op_valid drops while still in SEND
		release_held_credit();

		// Spend and return in one cycle
		drain_credits();
		for (int i = 0; i < SAME_CYCLE_OPS; i++) begin
			a = random_bits(32);
			b = random_bits(32);
			send_operands(a, b);
			collect_result(64'(a) * 64'(b), SAME_CYCLE_HOLD, 1'b0, RESULT_LATENCY, 1'b1);
			if (i > 0) begin
				check_value("res_credit", 64'd1, 64'(res_credit));
			end
		end
		drain_credits();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mul_top.f
+incdir+source
source/mul_pkg.sv
source/mul_ctrl_if.sv
source/mul_control.sv
source/mul_step_counter.sv
source/mul_operand_store.sv
source/mul_csa_accumulator.sv
source/mul_carry_resolve.sv
source/mul_top.sv
tb/mul_top_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module mul_top_tb -f mul_top.f -o mul_top_sim

# The pipeline status is the status of tee, the log decides the result
./obj_dir/mul_top_sim 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1
